// ==== src/isa_pkg.sv ====
// instruction-set definitions shared by the fetch stage and its testbench
// import inside a module body; use scoped names in port lists
`default_nettype none

package isa_pkg;

	// data and pc width
	localparam int xlen = 32;

	// nop opcode 01111 in the top five bits
	localparam logic [xlen-1:0] nop_instr = {5'b01111, 27'd0};

	// positions in the 2-bit flag vector
	localparam int flag_n_bit = 1;
	localparam int flag_z_bit = 0;

	// branch condition, carried in the low alu op bits
	typedef enum logic [1:0] {
		cond_eq = 2'd0, // z set
		cond_ne = 2'd1, // z clear
		cond_lt = 2'd2, // n set
		cond_ge = 2'd3  // n clear
	} branch_cond_e;

	// jump kind, same op bits as branches
	typedef enum logic [1:0] {
		jmp_abs  = 2'd0,
		jmp_link = 2'd1,
		jmp_reg  = 2'd2,
		jmp_none = 2'd3 // no redirect
	} jump_kind_e;

endpackage

`default_nettype wire

// ==== src/imem_pkg.sv ====
// instruction memory geometry and handshake timing
`default_nettype none

package imem_pkg;

	// rom size in words
	localparam int imem_depth = 64;
	localparam int imem_addr_w = 6;

	// cycles spent in wait before ack, at least one
	localparam int imem_wait = 2;

	// program image, looked up relative to the simulation directory
	localparam string imem_file = "imem_init.hex";

endpackage

`default_nettype wire

// ==== src/branch_resolve.sv ====
// redirect decision for the instruction at the execute/memory boundary
// purely combinational, feeds the pc unit in the same cycle
`default_nettype none

module branch_resolve (
	input  logic       ex_valid,
	input  logic       ex_branch,
	input  logic       ex_jump,
	input  logic [1:0] ex_op,
	input  logic [1:0] ex_flags,
	output logic       redirect
);
	import isa_pkg::*;

	branch_cond_e cond;
	jump_kind_e   kind;
	logic         cond_met;
	logic         taken;

	// same op bits read two ways
	assign cond = branch_cond_e'(ex_op);
	assign kind = jump_kind_e'(ex_op);

	// flag test for conditional branches
	always_comb begin
		case (cond)
			cond_eq: cond_met = ex_flags[flag_z_bit];
			cond_ne: cond_met = !ex_flags[flag_z_bit];
			cond_lt: cond_met = ex_flags[flag_n_bit];
			cond_ge: cond_met = !ex_flags[flag_n_bit];
			default: cond_met = 1'b0;
		endcase
	end

	// jump wins over branch when both are set
	always_comb begin
		if (ex_jump)
			taken = (kind != jmp_none);
		else if (ex_branch)
			taken = cond_met;
		else
			taken = 1'b0;
	end

	// only a resolved instruction may redirect
	assign redirect = ex_valid && taken;

endmodule

`default_nettype wire

// ==== src/pc_unit.sv ====
// program counter with restore, redirect, stall and sequential advance
// advance comes from the fetch controller once a word has been delivered
`default_nettype none

module pc_unit (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    advance,
	input  logic                    stall,
	input  logic                    flush,
	input  logic                    redirect,
	input  logic [isa_pkg::xlen-1:0] redirect_target,
	input  logic                    restore,
	input  logic [isa_pkg::xlen-1:0] restore_pc,
	output logic [isa_pkg::xlen-1:0] pc
);
	import isa_pkg::*;

	logic [xlen-1:0] pc_next;
	logic            step;

	// a flush means the pc must move even while stalled
	assign step = advance && (!stall || flush);

	// priority: restore, redirect, advance, hold
	always_comb begin
		if (restore)
			pc_next = restore_pc;
		else if (redirect)
			pc_next = redirect_target;
		else if (step)
			pc_next = pc + xlen'(4);
		else
			pc_next = pc;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else begin
			pc <= pc_next;
		end
	end

	// fetch addresses are word based
	a_pc_aligned: assert property (
		@(posedge clk) disable iff (!rst_n)
		pc[1:0] == 2'b00
	);

endmodule

`default_nettype wire

// ==== src/imem.sv ====
// instruction rom behind a four-phase req/ack port
// ack comes imem_wait+1 cycles after req and drops one cycle after req falls
`default_nettype none

module imem (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          imem_req,
	input  logic [imem_pkg::imem_addr_w-1:0] imem_addr,
	output logic                          imem_ack,
	output logic [isa_pkg::xlen-1:0]       imem_data
);
	import isa_pkg::*;
	import imem_pkg::*;

	localparam int cnt_w = $clog2(imem_wait + 1);

	typedef enum logic [1:0] {
		mem_idle,
		mem_wait,
		mem_ack
	} mem_state_e;

	logic [xlen-1:0] rom [imem_depth];
	mem_state_e      state;
	logic [cnt_w-1:0] wait_cnt;

	initial begin
		$readmemh(imem_file, rom);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= mem_idle;
			wait_cnt <= '0;
			imem_ack <= 1'b0;
		end else begin
			case (state)
				mem_idle: begin
					// first cycle of wait is already counted
					if (imem_req) begin
						wait_cnt <= cnt_w'(1);
						state    <= mem_wait;
					end
				end
				mem_wait: begin
					if (wait_cnt == cnt_w'(imem_wait)) begin
						imem_ack <= 1'b1;
						state    <= mem_ack;
					end else begin
						wait_cnt <= wait_cnt + cnt_w'(1);
					end
				end
				mem_ack: begin
					// hold ack until the requester lets go
					if (!imem_req) begin
						imem_ack <= 1'b0;
						state    <= mem_idle;
					end
				end
				default: state <= mem_idle;
			endcase
		end
	end

	// read word latched together with the ack edge
	always_ff @(posedge clk) begin
		if (state == mem_wait && wait_cnt == cnt_w'(imem_wait))
			imem_data <= rom[imem_addr];
	end

	// requester must not move the address mid transaction
	a_addr_stable: assert property (
		@(posedge clk) disable iff (!rst_n)
		imem_req |=> !imem_req || $stable(imem_addr)
	);

endmodule

`default_nettype wire

// ==== src/fetch_ctrl.sv ====
// fetch sequencing: one rom transaction per pc, then deliver the word
// handles injection at capture, flush to nop, and hold under stall
`default_nettype none

module fetch_ctrl (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [isa_pkg::xlen-1:0]       pc,
	input  logic                          stall,
	input  logic                          flush,
	input  logic                          use_cpu_injection,
	input  logic [isa_pkg::xlen-1:0]       cpu_injection,
	input  logic                          use_int_instr,
	input  logic [isa_pkg::xlen-1:0]       int_instr,
	output logic                          imem_req,
	output logic [imem_pkg::imem_addr_w-1:0] imem_addr,
	input  logic                          imem_ack,
	input  logic [isa_pkg::xlen-1:0]       imem_data,
	output logic                          advance,
	output logic [isa_pkg::xlen-1:0]       instr,
	output logic [isa_pkg::xlen-1:0]       instr_pc,
	output logic                          instr_valid
);
	import isa_pkg::*;
	import imem_pkg::*;

	typedef enum logic [1:0] {
		f_hold,
		f_req,
		f_release
	} fetch_state_e;

	fetch_state_e    state;
	logic [xlen-1:0] req_pc;
	logic [xlen-1:0] word_q;
	logic [xlen-1:0] instr_q;
	logic            instr_valid_q;
	logic            discard;
	logic            hold;
	logic            start;
	logic            done_hs;
	logic            stale;
	logic            drop;
	logic            deliver;

	assign hold = stall && !flush;

	// wait for the pc to take the last advance before sampling it
	assign start = (state == f_hold) && !advance && !flush && !stall;

	// handshake finished once ack is back low
	assign done_hs = (state == f_release) && !imem_ack;

	// pc moved by restore or redirect while in flight
	assign stale   = discard || flush || (pc != req_pc);
	assign drop    = done_hs && stale;
	assign deliver = done_hs && !stale;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= f_hold;
			imem_req <= 1'b0;
			discard  <= 1'b0;
		end else begin
			case (state)
				f_hold: begin
					if (start) begin
						imem_req <= 1'b1;
						state    <= f_req;
					end
				end
				f_req: begin
					if (imem_ack) begin
						imem_req <= 1'b0;
						state    <= f_release;
					end
				end
				f_release: begin
					// stay until ack is back low
					if (drop || deliver)
						state <= f_hold;
				end
				default: state <= f_hold;
			endcase

			// flush kills whatever is in flight
			if (drop || deliver)
				discard <= 1'b0;
			else if (flush && state != f_hold)
				discard <= 1'b1;
		end
	end

	// address and pc frozen for the whole transaction
	always_ff @(posedge clk) begin
		if (start) begin
			req_pc    <= pc;
			imem_addr <= pc[imem_addr_w+1:2];
		end
	end

	// injection overrides the rom word, cpu fsm first
	always_ff @(posedge clk) begin
		if (state == f_req && imem_ack) begin
			if (use_cpu_injection)
				word_q <= cpu_injection;
			else if (use_int_instr)
				word_q <= int_instr;
			else
				word_q <= imem_data;
		end
	end

	always_ff @(posedge clk) begin
		if (deliver) begin
			instr_q  <= word_q;
			instr_pc <= req_pc;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			instr_valid_q <= 1'b0;
			advance       <= 1'b0;
		end else begin
			if (flush)
				instr_valid_q <= 1'b0;
			else if (deliver)
				instr_valid_q <= 1'b1;
			else if (!stall)
				instr_valid_q <= 1'b0;

			// kept up until the pc unit can take it
			if (deliver)
				advance <= 1'b1;
			else if (!hold)
				advance <= 1'b0;
		end
	end

	// flushed slot shows a valid nop
	assign instr       = flush ? nop_instr : instr_q;
	assign instr_valid = instr_valid_q || flush;

	// four-phase rule, ack must drop before the next req
	a_req_after_ack: assert property (
		@(posedge clk) disable iff (!rst_n)
		$rose(imem_req) |-> !imem_ack
	);

endmodule

`default_nettype wire

// ==== src/fetch_top.sv ====
// fetch stage top: pc unit, branch resolver, fetch controller and rom
`default_nettype none

module fetch_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    stall,
	input  logic                    flush,
	input  logic                    ex_valid,
	input  logic                    ex_branch,
	input  logic                    ex_jump,
	input  logic [1:0]              ex_op,
	input  logic [1:0]              ex_flags,
	input  logic [isa_pkg::xlen-1:0] redirect_target,
	input  logic                    restore,
	input  logic [isa_pkg::xlen-1:0] restore_pc,
	input  logic                    use_cpu_injection,
	input  logic [isa_pkg::xlen-1:0] cpu_injection,
	input  logic                    use_int_instr,
	input  logic [isa_pkg::xlen-1:0] int_instr,
	output logic [isa_pkg::xlen-1:0] instr,
	output logic [isa_pkg::xlen-1:0] instr_pc,
	output logic                    instr_valid,
	output logic [isa_pkg::xlen-1:0] current_pc
);
	import isa_pkg::*;
	import imem_pkg::*;

	logic                   redirect;
	logic                   advance;
	logic                   imem_req;
	logic                   imem_ack;
	logic [imem_addr_w-1:0] imem_addr;
	logic [xlen-1:0]        imem_data;

	branch_resolve u_branch (
		.ex_valid (ex_valid),
		.ex_branch(ex_branch),
		.ex_jump  (ex_jump),
		.ex_op    (ex_op),
		.ex_flags (ex_flags),
		.redirect (redirect)
	);

	// current_pc doubles as the fetch pc
	pc_unit u_pc (
		.clk            (clk),
		.rst_n          (rst_n),
		.advance        (advance),
		.stall          (stall),
		.flush          (flush),
		.redirect       (redirect),
		.redirect_target(redirect_target),
		.restore        (restore),
		.restore_pc     (restore_pc),
		.pc             (current_pc)
	);

	fetch_ctrl u_ctrl (
		.clk              (clk),
		.rst_n            (rst_n),
		.pc               (current_pc),
		.stall            (stall),
		.flush            (flush),
		.use_cpu_injection(use_cpu_injection),
		.cpu_injection    (cpu_injection),
		.use_int_instr    (use_int_instr),
		.int_instr        (int_instr),
		.imem_req         (imem_req),
		.imem_addr        (imem_addr),
		.imem_ack         (imem_ack),
		.imem_data        (imem_data),
		.advance          (advance),
		.instr            (instr),
		.instr_pc         (instr_pc),
		.instr_valid      (instr_valid)
	);

	imem u_imem (
		.clk      (clk),
		.rst_n    (rst_n),
		.imem_req (imem_req),
		.imem_addr(imem_addr),
		.imem_ack (imem_ack),
		.imem_data(imem_data)
	);

endmodule

`default_nettype wire

// ==== verif/tb_fetch.sv ====
// fetch stage testbench: sequential, stall, injection, redirect and restore
// run from the project root so the program image path resolves
`default_nettype none

module tb_fetch;
	import isa_pkg::*;
	import imem_pkg::*;

	logic            clk;
	logic            rst_n;
	logic            stall;
	logic            flush;
	logic            ex_valid;
	logic            ex_branch;
	logic            ex_jump;
	logic [1:0]      ex_op;
	logic [1:0]      ex_flags;
	logic [xlen-1:0] redirect_target;
	logic            restore;
	logic [xlen-1:0] restore_pc;
	logic            use_cpu_injection;
	logic [xlen-1:0] cpu_injection;
	logic            use_int_instr;
	logic [xlen-1:0] int_instr;
	logic [xlen-1:0] instr;
	logic [xlen-1:0] instr_pc;
	logic            instr_valid;
	logic [xlen-1:0] current_pc;

	// model state
	logic [xlen-1:0] image [imem_depth];
	integer          seed;
	string           test_name;
	logic            rand_stall_en;
	integer          n_words;
	logic [xlen-1:0] exp_pc;
	logic            prev_valid;
	logic            prev_stall;
	logic [xlen-1:0] prev_instr;
	logic [xlen-1:0] prev_pc;
	integer          mode;
	integer          op;
	integer          fl;

	fetch_top uut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// word seen at capture time: cpu fsm first, then interrupt controller, then rom
	function automatic logic [xlen-1:0] expected_word(input logic [xlen-1:0] pc,
			input logic cpu_en, input logic [xlen-1:0] cpu_word,
			input logic int_en, input logic [xlen-1:0] int_word);
		if (cpu_en)
			return cpu_word;
		if (int_en)
			return int_word;
		return image[(pc >> 2) % imem_depth];
	endfunction

	// pc of the first word after a resolved execute-stage instruction
	function automatic logic [xlen-1:0] expected_next_pc(input logic branch,
			input logic jump, input logic [1:0] kind, input logic [1:0] flags,
			input logic [xlen-1:0] target, input logic [xlen-1:0] seq_pc);
		logic taken;
		taken = 1'b0;
		if (jump) begin
			taken = (kind != jmp_none);
		end else if (branch) begin
			case (kind)
				cond_eq: taken = flags[flag_z_bit];
				cond_ne: taken = !flags[flag_z_bit];
				cond_lt: taken = flags[flag_n_bit];
				default: taken = !flags[flag_n_bit];
			endcase
		end
		return taken ? target : seq_pc;
	endfunction

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [xlen-1:0] expected,
			input logic [xlen-1:0] actual);
		if (actual !== expected)
			stop_with_failure($sformatf("** Error [%s] expected %h, actual %h",
				name, expected, actual));
	endtask

	// returns on the rising edge after the next delivered word
	task automatic wait_word();
		integer goal;
		integer cycles;
		goal = n_words + 1;
		cycles = 0;
		while (n_words < goal) begin
			@(posedge clk);
			cycles = cycles + 1;
			if (n_words < goal && cycles >= 50)
				stop_with_failure($sformatf(
					"no instruction was delivered within 50 cycles in test %s", test_name));
		end
	endtask

	// one flush cycle carrying an execute-stage strobe, restore optional
	task automatic redirect_event(input logic branch, input logic jump,
			input logic [1:0] kind, input logic [1:0] flags, input logic [xlen-1:0] target,
			input logic do_restore, input logic [xlen-1:0] rpc);
		@(posedge clk);
		#5;
		flush = 1'b1;
		ex_valid = 1'b1;
		ex_branch = branch;
		ex_jump = jump;
		ex_op = kind;
		ex_flags = flags;
		redirect_target = target;
		restore = do_restore;
		restore_pc = rpc;
		if (do_restore)
			exp_pc = rpc;
		else
			exp_pc = expected_next_pc(branch, jump, kind, flags, target, exp_pc);
		@(posedge clk);
		#5;
		flush = 1'b0;
		ex_valid = 1'b0;
		ex_branch = 1'b0;
		ex_jump = 1'b0;
		restore = 1'b0;
		// pc takes the new value at the edge after the strobe
		check_value({test_name, " current pc"}, exp_pc, current_pc);
		wait_word();
	endtask

	// random stall windows; enable sampled on the edge itself
	always @(posedge clk) begin
		if (rand_stall_en) begin
			#5;
			stall = ($random(seed) % 2) != 0;
		end else begin
			#5;
			stall = 1'b0;
		end
	end

	// compare at the falling edge, where outputs have settled
	always @(negedge clk) begin
		if (rst_n) begin
			// a word held under stall stays valid
			if (prev_valid && prev_stall && !flush)
				check_value({test_name, " held valid"}, 1, instr_valid);
			if (instr_valid && flush) begin
				check_value({test_name, " flush nop"}, nop_instr, instr);
			end else if (instr_valid && prev_valid) begin
				if (!prev_stall)
					stop_with_failure({"instr_valid stayed high without a stall in test ",
						test_name});
				check_value({test_name, " held word"}, prev_instr, instr);
				check_value({test_name, " held pc"}, prev_pc, instr_pc);
			end else if (instr_valid) begin
				// fresh delivery, no pc may be skipped
				check_value({test_name, " pc"}, exp_pc, instr_pc);
				check_value({test_name, " word"}, expected_word(instr_pc,
					use_cpu_injection, cpu_injection, use_int_instr, int_instr), instr);
				exp_pc = instr_pc + 32'd4;
				n_words = n_words + 1;
			end
			prev_valid = instr_valid && !flush;
			prev_stall = stall;
			prev_instr = instr;
			prev_pc = instr_pc;
		end
	end

	initial begin
		seed = 74;
		rst_n = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		ex_valid = 1'b0;
		ex_branch = 1'b0;
		ex_jump = 1'b0;
		ex_op = 2'd0;
		ex_flags = 2'd0;
		redirect_target = '0;
		restore = 1'b0;
		restore_pc = '0;
		use_cpu_injection = 1'b0;
		cpu_injection = '0;
		use_int_instr = 1'b0;
		int_instr = '0;
		rand_stall_en = 1'b0;
		n_words = 0;
		exp_pc = '0;
		prev_valid = 1'b0;
		prev_stall = 1'b0;
		prev_instr = '0;
		prev_pc = '0;
		test_name = "reset";
		$readmemh("verif/imem_init.hex", image);
		// rom gets the same image, path from the project root
		#1;
		$readmemh("verif/imem_init.hex", uut.u_imem.rom);
		repeat (4) @(posedge clk);
		#5;
		rst_n = 1'b1;

		test_name = "sequential";
		repeat (8) wait_word();

		test_name = "stall";
		#5;
		rand_stall_en = 1'b1;
		repeat (12) wait_word();
		#5;
		rand_stall_en = 1'b0;

		// 1 cpu only, 2 interrupt only, 3 both
		test_name = "injection";
		for (mode = 1; mode <= 3; mode = mode + 1) begin
			use_cpu_injection = mode[0];
			use_int_instr = mode[1];
			cpu_injection = $random(seed);
			int_instr = $random(seed);
			repeat (2) wait_word();
			#5;
		end
		use_cpu_injection = 1'b0;
		use_int_instr = 1'b0;

		test_name = "branch";
		for (op = 0; op < 4; op = op + 1)
			for (fl = 0; fl < 4; fl = fl + 1)
				redirect_event(1'b1, 1'b0, op[1:0], fl[1:0], $random(seed) & 32'hfc,
					1'b0, '0);

		test_name = "jump";
		for (op = 0; op < 4; op = op + 1)
			redirect_event(1'b0, 1'b1, op[1:0], 2'b00, $random(seed) & 32'hfc, 1'b0, '0);

		// second case has a taken jump in the same cycle
		test_name = "restore";
		redirect_event(1'b0, 1'b0, 2'd0, 2'd0, '0, 1'b1, 32'h40);
		redirect_event(1'b0, 1'b1, jmp_abs, 2'd0, 32'h80, 1'b1, 32'h20);

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/isa_pkg.sv
src/imem_pkg.sv
src/branch_resolve.sv
src/pc_unit.sv
src/imem.sv
src/fetch_ctrl.sv
src/fetch_top.sv
verif/tb_fetch.sv

// ==== Bender.yml ====
package:
  name: fetch_stage

sources:
  - src/isa_pkg.sv
  - src/imem_pkg.sv
  - src/branch_resolve.sv
  - src/pc_unit.sv
  - src/imem.sv
  - src/fetch_ctrl.sv
  - src/fetch_top.sv
  - target: test
    files:
      - verif/tb_fetch.sv

// ==== verif/imem_init.hex ====
// one 32-bit instruction word per entry, four entries per line, from word address 0
// word layout: a5, word address, 5a, 3f minus word address
a5005a3f a5015a3e a5025a3d a5035a3c
a5045a3b a5055a3a a5065a39 a5075a38
a5085a37 a5095a36 a50a5a35 a50b5a34
a50c5a33 a50d5a32 a50e5a31 a50f5a30
a5105a2f a5115a2e a5125a2d a5135a2c
a5145a2b a5155a2a a5165a29 a5175a28
a5185a27 a5195a26 a51a5a25 a51b5a24
a51c5a23 a51d5a22 a51e5a21 a51f5a20
a5205a1f a5215a1e a5225a1d a5235a1c
a5245a1b a5255a1a a5265a19 a5275a18
a5285a17 a5295a16 a52a5a15 a52b5a14
a52c5a13 a52d5a12 a52e5a11 a52f5a10
a5305a0f a5315a0e a5325a0d a5335a0c
a5345a0b a5355a0a a5365a09 a5375a08
a5385a07 a5395a06 a53a5a05 a53b5a04
a53c5a03 a53d5a02 a53e5a01 a53f5a00
